// ==== Bender.yml ====
package:
  name: sport_rx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sportPkg.sv
      - rtl/sportRxIf.sv
      - rtl/rxCtrlDecode.sv
      - rtl/rxShiftExec.sv
      - rtl/rxResult.sv
      - rtl/sportRx.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/sportRxTb.sv

// ==== all.f ====
+incdir+rtl
rtl/sportPkg.sv
rtl/sportRxIf.sv
rtl/rxCtrlDecode.sv
rtl/rxShiftExec.sv
rtl/rxResult.sv
rtl/sportRx.sv
tb/sportRxTb.sv

// ==== rtl/rxCtrlDecode.sv ====
`timescale 1ns/1ns
`include "sport_config.svh"

module rxCtrlDecode (
  input  logic                     SCLKg4,
  input  logic                     rst_SP_EN,
  input  logic [`SPORT_ADDR_W-1:0] paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`SPORT_DATA_W-1:0] pwdata,
  output logic [`SPORT_DATA_W-1:0] prdata,
  output logic                     pready,
  output logic                     pslverr,
  sportRxIf.decode                 rxIf
);
  import sportPkg::*;

  rxCfg_t    ctrlReg;
  rxStatus_t statWord;
  logic      access;
  logic      isCtrl;
  logic      isStat;
  logic      isData;
  logic      unmapped;

  assign access   = psel && penable;
  assign isCtrl   = (paddr == `SPORT_CTRL_ADDR);
  assign isStat   = (paddr == `SPORT_STAT_ADDR);
  assign isData   = (paddr == `SPORT_DATA_ADDR);
  assign unmapped = !(isCtrl || isStat || isData);

  // no wait states.
  assign pready  = 1'b1;
  assign pslverr = access && (unmapped || (pwrite && isData));

  // control register, written at the end of the access cycle.
  always_ff @(posedge SCLKg4 or posedge rst_SP_EN) begin
    if (rst_SP_EN) begin
      ctrlReg <= '0;
    end else if (access && pwrite && isCtrl) begin
      ctrlReg.enable  <= pwdata[0];
      ctrlReg.dtype   <= rxDtype_e'(pwdata[2:1]);
      ctrlReg.slen    <= pwdata[7:4];
      ctrlReg.wordCnt <= pwdata[15:8];
      ctrlReg.irqEn   <= pwdata[16];
    end
  end

  assign rxIf.cfg = ctrlReg;

  // one cycle pulses, the result block acts on them at the same edge.
  assign rxIf.dataRead = access && !pwrite && isData;
  assign rxIf.ovfClear = access && pwrite && isStat && pwdata[1];

  // busy comes from the shifter, the flags from the buffer.
  assign statWord = '{busy: rxIf.busy,
                      overflow: rxIf.status.overflow,
                      full: rxIf.status.full};

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        `SPORT_CTRL_ADDR: begin
          prdata = `SPORT_DATA_W'({ctrlReg.irqEn, ctrlReg.wordCnt, ctrlReg.slen,
                                   1'b0, ctrlReg.dtype, ctrlReg.enable});
        end
        `SPORT_STAT_ADDR: prdata = `SPORT_DATA_W'(statWord);
        `SPORT_DATA_ADDR: prdata = `SPORT_DATA_W'(rxIf.rxData);
        default:          prdata = '0;
      endcase
    end
  end

endmodule

// ==== rtl/rxResult.sv ====
`timescale 1ns/1ns

module rxResult (
  input  logic SCLKg4,
  input  logic rst_SP_EN,
  output logic rxIrq,
  sportRxIf.result rxIf
);
  import sportPkg::*;

  rxCompand_t  muCode;
  rxCompand_t  aCode;
  logic [3:0]  slenEff;
  logic [15:0] mask;
  logic [15:0] signExt;
  logic [15:0] muMag;
  logic [15:0] aMag;
  logic [15:0] muVal;
  logic [15:0] aVal;
  logic [15:0] extWord;
  logic [15:0] rxBuf;
  logic        full;
  logic        fullNext;
  logic        overflow;

  assign slenEff = (rxIf.cfg.slen < 4'd3) ? 4'd3 : rxIf.cfg.slen;
  assign mask    = 16'hffff >> (4'd15 - slenEff);

  // word arrives masked, so zero extension is the word itself.
  assign signExt = rxIf.word.linear[slenEff] ? (rxIf.word.linear | ~mask)
                                             : rxIf.word.linear;

  // mu-law code is stored inverted.
  assign muCode = rxIf.word.compand ^ 16'h00ff;

  // A-law code has its even bits toggled by 0x55.
  assign aCode = rxIf.word.compand ^ 16'h0055;

  // add the bias of 132 and remove it again after the shift.
  assign muMag = (({9'd0, muCode.mant, 3'd0} + 16'd132) << muCode.exp) - 16'd132;
  assign muVal = muCode.sign ? (16'd0 - muMag) : muMag;

  always_comb begin
    if (aCode.exp == 3'd0) begin
      aMag = {8'd0, aCode.mant, 4'd0} + 16'd8;
    end else begin
      aMag = ({8'd0, aCode.mant, 4'd0} + 16'd264) << (aCode.exp - 3'd1);
    end
  end

  assign aVal = aCode.sign ? aMag : (16'd0 - aMag); // sign 0 means negative.

  always_comb begin
    case (rxIf.cfg.dtype)
      DT_ZERO: extWord = rxIf.word.linear;
      DT_SIGN: extWord = signExt;
      DT_ULAW: extWord = muVal;
      DT_ALAW: extWord = aVal;
      default: extWord = rxIf.word.linear;
    endcase
  end

  // a new word simply overwrites the receive buffer.
  always_ff @(posedge SCLKg4 or posedge rst_SP_EN) begin
    if (rst_SP_EN) begin
      rxBuf <= 16'h0000;
    end else if (rxIf.wordValid) begin
      rxBuf <= extWord;
    end
  end

  assign fullNext = rxIf.wordValid || (full && !rxIf.dataRead);

  always_ff @(posedge SCLKg4 or posedge rst_SP_EN) begin
    if (rst_SP_EN) begin
      full     <= 1'b0;
      overflow <= 1'b0;
      rxIrq    <= 1'b0;
    end else begin
      full  <= fullNext;
      rxIrq <= fullNext && rxIf.cfg.irqEn;
      if (rxIf.ovfClear) overflow <= 1'b0;
      if (rxIf.wordValid && full && !rxIf.dataRead) overflow <= 1'b1; // sticky.
    end
  end

  assign rxIf.status = '{busy: 1'b0, overflow: overflow, full: full};
  assign rxIf.rxData = rxBuf;

endmodule

// ==== rtl/rxShiftExec.sv ====
`timescale 1ns/1ns

module rxShiftExec (
  input  logic SCLKg4,
  input  logic rst_SP_EN,
  input  logic rfs,
  input  logic rd,
  sportRxIf.exec rxIf
);

  // one-hot frame states.
  localparam logic [2:0] stIdle   = 3'b001;
  localparam logic [2:0] stShift  = 3'b010;
  localparam logic [2:0] stWstart = 3'b100;

  logic [2:0]  state;
  logic [2:0]  nextState;
  logic [3:0]  bitCnt;
  logic [7:0]  wordLeft;
  logic [15:0] shiftReg;
  logic [15:0] mask;
  logic [3:0]  slenEff;
  logic        lastBit;
  logic        wordValid;

  // words shorter than four bits are not supported.
  assign slenEff = (rxIf.cfg.slen < 4'd3) ? 4'd3 : rxIf.cfg.slen;
  assign mask    = 16'hffff >> (4'd15 - slenEff);

  // wstart always holds the first bit of a word, so only shift can end one.
  assign lastBit = state[1] && (bitCnt == 4'd0);

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (rxIf.cfg.enable && rfs) nextState = stShift; // rfs ignored once running.
      end
      stShift: begin
        if (lastBit) begin
          nextState = (wordLeft == 8'd0) ? stIdle : stWstart;
        end
      end
      stWstart: nextState = stShift;
      default:  nextState = stIdle;
    endcase
    if (!rxIf.cfg.enable) nextState = stIdle; // partial word is dropped.
  end

  always_ff @(posedge SCLKg4 or posedge rst_SP_EN) begin
    if (rst_SP_EN) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  // bit counter, reloaded in idle and at every word start.
  always_ff @(posedge SCLKg4 or posedge rst_SP_EN) begin
    if (rst_SP_EN) begin
      bitCnt <= 4'd0;
    end else if (state[0] || nextState[2]) begin
      bitCnt <= slenEff;
    end else begin
      bitCnt <= bitCnt - 4'd1;
    end
  end

  always_ff @(posedge SCLKg4 or posedge rst_SP_EN) begin
    if (rst_SP_EN) begin
      wordLeft <= 8'd0;
    end else if (state[0]) begin
      wordLeft <= rxIf.cfg.wordCnt;
    end else if (nextState[2]) begin
      wordLeft <= wordLeft - 8'd1;
    end
  end

  // MSB first, one bit per cycle outside idle.
  always_ff @(posedge SCLKg4) begin
    if (!state[0]) shiftReg <= {shiftReg[14:0], rd};
  end

  always_ff @(posedge SCLKg4 or posedge rst_SP_EN) begin
    if (rst_SP_EN) begin
      wordValid <= 1'b0;
    end else begin
      wordValid <= lastBit && rxIf.cfg.enable;
    end
  end

  assign rxIf.wordValid   = wordValid;
  assign rxIf.word.linear = shiftReg & mask; // stable for the cycle after the last bit.
  assign rxIf.busy        = !state[0];

endmodule

// ==== rtl/sportPkg.sv ====
package sportPkg;

  // receive data type, picks how a word is extended to 16 bits.
  typedef enum logic [1:0] {
    DT_ZERO = 2'b00,
    DT_SIGN = 2'b01,
    DT_ULAW = 2'b10,
    DT_ALAW = 2'b11
  } rxDtype_e;

  typedef struct packed {
    logic       enable;
    logic       irqEn;
    rxDtype_e   dtype;
    logic [3:0] slen;    // word length minus one.
    logic [7:0] wordCnt; // words per frame minus one.
  } rxCfg_t;

  // companded code, sits in the low byte.
  typedef struct packed {
    logic [7:0] pad;
    logic       sign;
    logic [2:0] exp;
    logic [3:0] mant;
  } rxCompand_t;

  typedef union packed {
    logic [15:0] linear;
    rxCompand_t  compand;
  } rxWord_u;

  // field order puts full at bit 0, as in STAT.
  typedef struct packed {
    logic busy;
    logic overflow;
    logic full;
  } rxStatus_t;

endpackage

// ==== rtl/sportRx.sv ====
`timescale 1ns/1ns
`include "sport_config.svh"

module sportRx (
  input  logic                     SCLKg4,
  input  logic                     rst_SP_EN,
  input  logic [`SPORT_ADDR_W-1:0] paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`SPORT_DATA_W-1:0] pwdata,
  output logic [`SPORT_DATA_W-1:0] prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  logic                     rfs,
  input  logic                     rd,
  output logic                     rxIrq
);

  sportRxIf rxIf ();

  // APB registers and read mux.
  rxCtrlDecode ctrlDecode (
    .SCLKg4    (SCLKg4),
    .rst_SP_EN (rst_SP_EN),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rxIf      (rxIf.decode)
  );

  rxShiftExec shiftExec (
    .SCLKg4    (SCLKg4),
    .rst_SP_EN (rst_SP_EN),
    .rfs       (rfs),
    .rd        (rd),
    .rxIf      (rxIf.exec)
  );

  rxResult result (
    .SCLKg4    (SCLKg4),
    .rst_SP_EN (rst_SP_EN),
    .rxIrq     (rxIrq),
    .rxIf      (rxIf.result)
  );

endmodule

// ==== rtl/sportRxIf.sv ====
`timescale 1ns/1ns

interface sportRxIf;
  import sportPkg::*;

  rxCfg_t      cfg;
  logic        wordValid;
  rxWord_u     word;      // raw word, right justified and masked.
  logic        busy;
  logic        dataRead;
  logic        ovfClear;
  rxStatus_t   status;    // busy field unused here.
  logic [15:0] rxData;

  modport decode (
    output cfg, dataRead, ovfClear,
    input  busy, status, rxData
  );

  modport exec (
    input  cfg,
    output wordValid, word, busy
  );

  modport result (
    input  cfg, wordValid, word, dataRead, ovfClear,
    output status, rxData
  );

endinterface

// ==== rtl/sport_config.svh ====
`ifndef SPORT_CONFIG_SVH
`define SPORT_CONFIG_SVH

// APB bus widths.
`define SPORT_ADDR_W 4
`define SPORT_DATA_W 32

// register offsets, byte addressed.
`define SPORT_CTRL_ADDR 4'h0
`define SPORT_STAT_ADDR 4'h4
`define SPORT_DATA_ADDR 4'h8

`endif

// ==== tb/sportRxTb.sv ====
`timescale 1ns/1ns
`include "sport_config.svh"

module sportRxTb;
  import sportPkg::*;

  localparam int nRows = 9;
  localparam logic [31:0] lfsrSeed = 32'h9ec8_2ddc;
  localparam int resetCycles = 10;

  logic                     SCLKg4;
  logic                     rst_SP_EN;
  logic [`SPORT_ADDR_W-1:0] paddr;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`SPORT_DATA_W-1:0] pwdata;
  logic [`SPORT_DATA_W-1:0] prdata;
  logic                     pready;
  logic                     pslverr;
  logic                     rfs;
  logic                     rd;
  logic                     rxIrq;

  // one frame per row of the stimulus table.
  string       rowName [nRows];
  logic [31:0] rowCtrl [nRows];
  int          rowWords [nRows];
  logic        rowPulse [nRows];
  logic [15:0] rowData [nRows][4];
  logic [15:0] rowExp [nRows][4];

  logic [31:0] lfsrState;
  int          mismatchCnt;
  int          failCnt;
  int          cycleCnt;
  int          cycleLimit;

  sportRx sportRx_inst (
    .SCLKg4    (SCLKg4),
    .rst_SP_EN (rst_SP_EN),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rfs       (rfs),
    .rd        (rd),
    .rxIrq     (rxIrq)
  );

  initial begin
    SCLKg4 = 1'b0;
    forever #20 SCLKg4 = ~SCLKg4;
  end

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) s = s ^ 32'h8020_0003;
    return s;
  endfunction

  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v         = {v[14:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
    return v;
  endfunction

  function automatic logic [31:0] makeCtrl(input logic en, input rxDtype_e dt, input int slen,
                                           input int wc, input logic irq);
    logic [31:0] v;
    v       = '0;
    v[0]    = en;
    v[2:1]  = dt;
    v[7:4]  = slen[3:0];
    v[15:8] = wc[7:0];
    v[16]   = irq;
    return v;
  endfunction

  function automatic rxStatus_t statusOf(input logic busy, input logic ovf, input logic full);
    rxStatus_t s;
    s.busy     = busy;
    s.overflow = ovf;
    s.full     = full;
    return s;
  endfunction

  // expected 16-bit result from the G.711 and extension rules.
  function automatic logic [15:0] expectWord(input logic [31:0] ctrl, input logic [15:0] raw);
    int          slen;
    int          e;
    int          m;
    int          mag;
    int          lin;
    logic [7:0]  c;
    slen = ctrl[7:4];
    if (slen < 3) slen = 3;
    lin = raw & ((1 << (slen + 1)) - 1);
    case (rxDtype_e'(ctrl[2:1]))
      DT_ZERO: return 16'(lin);
      DT_SIGN: return (lin >= (1 << slen)) ? 16'(lin - (1 << (slen + 1))) : 16'(lin);
      DT_ULAW: begin
        c   = ~raw[7:0];
        e   = c[6:4];
        m   = c[3:0];
        mag = (((m << 3) + 132) << e) - 132;
        return c[7] ? 16'(-mag) : 16'(mag);
      end
      default: begin
        c   = raw[7:0] ^ 8'h55;
        e   = c[6:4];
        m   = c[3:0];
        mag = (e == 0) ? ((m << 4) + 8) : (((m << 4) + 264) << (e - 1));
        return c[7] ? 16'(mag) : 16'(-mag); // sign 0 is negative.
      end
    endcase
  endfunction

  function automatic int frameBudget(input int words);
    return words * 16 + 40;
  endfunction

  task automatic addRow(input int idx, input string name, input rxDtype_e dt, input int slen,
                        input int n, input logic pulse);
    int w;
    rowName[idx]  = name;
    rowCtrl[idx]  = makeCtrl(1'b1, dt, slen, n - 1, 1'b0);
    rowWords[idx] = n;
    rowPulse[idx] = pulse;
    for (w = 0; w < 4; w++) rowData[idx][w] = randBits(slen + 1);
    if (dt == DT_SIGN) rowData[idx][0][slen] = 1'b1; // at least one negative word.
  endtask

  task automatic buildTable();
    int i;
    int w;
    addRow(0, "zero8", DT_ZERO, 7, 2, 1'b0);
    addRow(1, "sign12", DT_SIGN, 11, 2, 1'b0);
    addRow(2, "zero16", DT_ZERO, 15, 1, 1'b0);
    addRow(3, "sign16", DT_SIGN, 15, 2, 1'b0);
    addRow(4, "ulawEdges", DT_ULAW, 7, 4, 1'b0);
    addRow(5, "alawEdges", DT_ALAW, 7, 4, 1'b0);
    addRow(6, "ulawRand", DT_ULAW, 7, 2, 1'b0);
    addRow(7, "alawRand", DT_ALAW, 7, 2, 1'b0);
    addRow(8, "multi12", DT_ZERO, 11, 4, 1'b1);
    for (i = 4; i <= 5; i++) begin
      rowData[i][0] = 16'h0000;
      rowData[i][1] = 16'h007f;
      rowData[i][2] = 16'h0080;
      rowData[i][3] = 16'h00ff;
    end
    for (i = 0; i < nRows; i++) begin
      for (w = 0; w < 4; w++) rowExp[i][w] = expectWord(rowCtrl[i], rowData[i][w]);
    end
  endtask

  task automatic checkData(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      mismatchCnt++;
    end
  endtask

  task automatic checkStatus(input string name, input rxStatus_t exp, input rxStatus_t act);
    if (exp !== act) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      mismatchCnt++;
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      mismatchCnt++;
    end
  endtask

  // outputs are sampled in the middle of the access cycle.
  task automatic apbRead(input logic [`SPORT_ADDR_W-1:0] addr,
                         output logic [`SPORT_DATA_W-1:0] data, output logic err);
    @(posedge SCLKg4);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge SCLKg4);
    penable <= 1'b1;
    @(negedge SCLKg4);
    data = prdata;
    err  = pslverr;
    @(posedge SCLKg4);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbWrite(input logic [`SPORT_ADDR_W-1:0] addr,
                          input logic [`SPORT_DATA_W-1:0] data, output logic err);
    @(posedge SCLKg4);
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge SCLKg4);
    penable <= 1'b1;
    @(negedge SCLKg4);
    err = pslverr;
    @(posedge SCLKg4);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // bits go out MSB first with an optional rfs pulse on bit slen-2 of every word.
  task automatic sendFrame(input logic [63:0] words, input int n, input int slen,
                           input logic pulse);
    int          w;
    int          b;
    logic [15:0] cur;
    @(posedge SCLKg4);
    rfs <= 1'b1;
    for (w = 0; w < n; w++) begin
      cur = words[w*16 +: 16];
      for (b = slen; b >= 0; b--) begin
        @(posedge SCLKg4);
        rd  <= cur[b];
        rfs <= pulse && (b == slen - 2);
      end
    end
    @(posedge SCLKg4);
    rfs <= 1'b0;
    rd  <= 1'b0;
  endtask

  task automatic waitStat(input string name, input int bitIdx);
    logic [`SPORT_DATA_W-1:0] data;
    logic                     err;
    int                       polls;
    polls = 0;
    data  = '0;
    while (!data[bitIdx] && polls < 50) begin
      apbRead(`SPORT_STAT_ADDR, data, err);
      polls++;
    end
    if (!data[bitIdx]) begin
      $display("%s: STAT bit %0d was never set while polling", name, bitIdx);
      failCnt++;
    end
  endtask

  task automatic readWords(input int idx);
    logic [`SPORT_DATA_W-1:0] data;
    logic                     err;
    int                       w;
    for (w = 0; w < rowWords[idx]; w++) begin
      waitStat(rowName[idx], 0);
      apbRead(`SPORT_DATA_ADDR, data, err);
      checkData($sformatf("%s word %0d", rowName[idx], w), rowExp[idx][w], data[15:0]);
    end
  endtask

  task automatic runRow(input int idx);
    logic [`SPORT_DATA_W-1:0] data;
    logic                     err;
    apbWrite(`SPORT_CTRL_ADDR, rowCtrl[idx], err);
    fork
      sendFrame({rowData[idx][3], rowData[idx][2], rowData[idx][1], rowData[idx][0]},
                rowWords[idx], rowCtrl[idx][7:4], rowPulse[idx]);
      readWords(idx);
    join
    apbRead(`SPORT_STAT_ADDR, data, err);
    checkStatus({rowName[idx], " stat"}, statusOf(1'b0, 1'b0, 1'b0), rxStatus_t'(data[2:0]));
  endtask

  task automatic testRegisters();
    logic [`SPORT_DATA_W-1:0] data;
    logic                     err;
    apbRead(`SPORT_STAT_ADDR, data, err);
    checkStatus("reset stat", statusOf(1'b0, 1'b0, 1'b0), rxStatus_t'(data[2:0]));
    checkBit("reset stat pslverr", 1'b0, err);
    apbRead(`SPORT_DATA_ADDR, data, err);
    checkData("reset data", 16'h0000, data[15:0]);
    @(negedge SCLKg4);
    checkBit("reset irq", 1'b0, rxIrq);
    checkBit("pready", 1'b1, pready);
    apbWrite(`SPORT_CTRL_ADDR, 32'h0001_3c75, err);
    checkBit("ctrl write pslverr", 1'b0, err);
    apbRead(`SPORT_CTRL_ADDR, data, err);
    checkData("ctrl readback low", 16'h3c75, data[15:0]);
    checkData("ctrl readback high", 16'h0001, data[31:16]);
    apbRead(4'hc, data, err);
    checkBit("unmapped pslverr", 1'b1, err);
    apbWrite(`SPORT_DATA_ADDR, 32'h0000_beef, err);
    checkBit("data write pslverr", 1'b1, err);
    apbRead(`SPORT_DATA_ADDR, data, err);
    checkData("data after write", 16'h0000, data[15:0]);
    apbWrite(`SPORT_CTRL_ADDR, 32'h0, err);
  endtask

  task automatic testOverflowIrq();
    logic [`SPORT_DATA_W-1:0] data;
    logic                     err;
    logic [15:0]              w0;
    logic [15:0]              w1;
    w0 = randBits(8);
    w1 = randBits(8);
    apbWrite(`SPORT_CTRL_ADDR, makeCtrl(1'b1, DT_ZERO, 7, 1, 1'b1), err);
    sendFrame({32'h0, w1, w0}, 2, 7, 1'b0); // no read between the two words.
    waitStat("overflow", 1);
    apbRead(`SPORT_STAT_ADDR, data, err);
    checkStatus("overflow stat", statusOf(1'b0, 1'b1, 1'b1), rxStatus_t'(data[2:0]));
    @(negedge SCLKg4);
    checkBit("irq while full", 1'b1, rxIrq);
    apbRead(`SPORT_DATA_ADDR, data, err);
    checkData("overflow keeps second", w1, data[15:0]);
    @(negedge SCLKg4);
    checkBit("irq after read", 1'b0, rxIrq);
    apbRead(`SPORT_STAT_ADDR, data, err);
    checkStatus("overflow sticky", statusOf(1'b0, 1'b1, 1'b0), rxStatus_t'(data[2:0]));
    apbWrite(`SPORT_STAT_ADDR, 32'h2, err);
    apbRead(`SPORT_STAT_ADDR, data, err);
    checkStatus("overflow cleared", statusOf(1'b0, 1'b0, 1'b0), rxStatus_t'(data[2:0]));
    w0 = randBits(8);
    apbWrite(`SPORT_CTRL_ADDR, makeCtrl(1'b1, DT_ZERO, 7, 0, 1'b0), err);
    sendFrame({48'h0, w0}, 1, 7, 1'b0);
    waitStat("irq masked", 0);
    @(negedge SCLKg4);
    checkBit("irq masked", 1'b0, rxIrq);
    apbRead(`SPORT_DATA_ADDR, data, err);
    checkData("irq masked data", w0, data[15:0]);
  endtask

  task automatic testDisable();
    logic [`SPORT_DATA_W-1:0] data;
    logic                     err;
    logic [15:0]              w0;
    w0 = randBits(16);
    apbWrite(`SPORT_CTRL_ADDR, makeCtrl(1'b1, DT_ZERO, 15, 0, 1'b1), err);
    fork
      sendFrame({48'h0, w0}, 1, 15, 1'b0);
      begin
        repeat (2) @(posedge SCLKg4);
        apbRead(`SPORT_STAT_ADDR, data, err);
        checkStatus("busy mid word", statusOf(1'b1, 1'b0, 1'b0), rxStatus_t'(data[2:0]));
        apbWrite(`SPORT_CTRL_ADDR, makeCtrl(1'b0, DT_ZERO, 15, 0, 1'b1), err);
      end
    join
    apbRead(`SPORT_STAT_ADDR, data, err);
    checkStatus("disable drops word", statusOf(1'b0, 1'b0, 1'b0), rxStatus_t'(data[2:0]));
    @(negedge SCLKg4);
    checkBit("disable irq", 1'b0, rxIrq);
  endtask

  // the run limit counts the directed tests as rows too.
  initial begin
    cycleCnt = 0;
    @(posedge SCLKg4);
    while (cycleCnt < cycleLimit) begin
      @(posedge SCLKg4);
      cycleCnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int i;
    int budget;
    rst_SP_EN   = 1'b1;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    rfs         = 1'b0;
    rd          = 1'b0;
    mismatchCnt = 0;
    failCnt     = 0;
    lfsrState   = lfsrSeed;
    buildTable();
    budget = frameBudget(0) + frameBudget(3) + frameBudget(1);
    for (i = 0; i < nRows; i++) budget += frameBudget(rowWords[i]);
    cycleLimit = 2 * budget + resetCycles;

    repeat (resetCycles) @(posedge SCLKg4);
    rst_SP_EN <= 1'b0;

    testRegisters();
    for (i = 0; i < nRows; i++) runRow(i);
    testOverflowIrq();
    testDisable();

    $display("errors: %0d mismatches, %0d other failures", mismatchCnt, failCnt);
    if (mismatchCnt == 0 && failCnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
